// File: Makefile
all: run

compile:
	verilator --binary --assert --top-module tb_tetris_game -f flist.f -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Checks failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all compile run clean

// File: board_writer.sv
module board_writer import tetris_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  frame_ctl_t  ctl,
	input  piece_t      piece,
	input  shape_t      shape,
	output board_addr_t wr_addr,
	output cell_t       wr_data,
	output logic        wr_en
);

	logic active; // Erase or write step

	assign active = ctl.phase inside {PH_ERASE, PH_WRITE};

	// Strobe one cycle behind the step
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			wr_en <= 1'b0;
		else
			wr_en <= active;
	end

	////////////////////
	// Cell address, data
	////////////////////
	always_ff @(posedge clk)
	begin
		if (active)
		begin
			wr_addr <= cell_addr(piece, shape[ctl.idx[1:0]]);
			wr_data <= (ctl.phase == PH_WRITE) ? piece.id : '0; // Erase writes empty
		end
	end

	// Only cell steps 0..3 write, so no cell index wraps
	assert property (@(posedge clk) disable iff (!rst_n)
		wr_en |-> $past(ctl.idx) <= 3'd3);

endmodule

// File: collision_checker.sv
module collision_checker import tetris_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  frame_ctl_t  ctl,
	input  piece_t      piece,
	input  shape_t      shape,
	input  cell_t       rd_data,
	output board_addr_t rd_addr,
	output moves_t      moves
);

	rot_t        next_rot;
	shape_t      next_shape;   // Offsets one rotation on
	logic        is_chk;
	logic        use_next;     // Rotate check reads next offsets
	logic [1:0]  rd_k;         // Cell being addressed
	logic [1:0]  ev_k;         // Cell whose data is back
	logic        ev_win;       // idx 2..5
	logic [4:0]  d_row;
	logic [5:0]  d_col;        // Two's complement shift
	moves_t      sel;          // Flag owned by this phase
	cell_ofs_t   rd_ofs;
	cell_ofs_t   ev_ofs;
	board_addr_t rd_tgt;
	board_addr_t ev_tgt;
	board_addr_t own_addr [4]; // Piece cells as drawn now
	logic        is_own;
	logic        blocked;

	// Target cell of a move
	function automatic board_addr_t moved(input piece_t p, input cell_ofs_t ofs,
		input logic [4:0] dr, input logic [5:0] dc);
		board_addr_t a;
		a = cell_addr(p, ofs);
		a.rc.row = a.rc.row + dr;
		a.rc.col = a.rc.col + dc;
		return a;
	endfunction

	assign next_rot = piece.rot + 2'd1;

	shape_rom u_next_rom (
		.id    (piece.id),
		.rot   (next_rot),
		.shape (next_shape)
	);

	assign is_chk   = ctl.phase inside {PH_CHK_DOWN, PH_CHK_LEFT, PH_CHK_RIGHT, PH_CHK_ROT};
	assign use_next = ctl.phase == PH_CHK_ROT;
	assign rd_k     = ctl.idx[1:0];
	assign ev_k     = 2'(ctl.idx - 3'd2); // Read data lags address by two steps
	assign ev_win   = (ctl.idx >= 3'd2) && (ctl.idx <= 3'd5);

	// Shift and flag per check
	always_comb
	begin
		d_row = '0;
		d_col = '0;
		sel   = '0;
		case (ctl.phase)
			PH_CHK_DOWN:
			begin
				d_row        = 5'd1;
				sel.can_down = 1'b1;
			end
			PH_CHK_LEFT:
			begin
				d_col        = '1; // Minus one
				sel.can_left = 1'b1;
			end
			PH_CHK_RIGHT:
			begin
				d_col         = 6'd1;
				sel.can_right = 1'b1;
			end
			PH_CHK_ROT:
				sel.can_rot = 1'b1; // No shift, new offsets
			default:
			begin
			end
		endcase
	end

	assign rd_ofs = use_next ? next_shape[rd_k] : shape[rd_k];
	assign ev_ofs = use_next ? next_shape[ev_k] : shape[ev_k];
	assign rd_tgt = moved(piece, rd_ofs, d_row, d_col);
	assign ev_tgt = moved(piece, ev_ofs, d_row, d_col);

	always_comb
	begin
		for (int j = 0; j < 4; j++)
			own_addr[j] = cell_addr(piece, shape[j]);
	end

	////////////////////
	// Blocking test
	////////////////////
	always_comb
	begin
		is_own = 1'b0;
		for (int j = 0; j < 4; j++)
		begin
			if (own_addr[j].flat == ev_tgt.flat)
				is_own = 1'b1; // Piece never blocks itself
		end
		blocked = (rd_data != '0) && !is_own;
		case (ctl.phase)
			PH_CHK_DOWN:
				if (ev_tgt.rc.row == Y_END)
					blocked = 1'b1;
			PH_CHK_RIGHT:
				if (ev_tgt.rc.col == X_END)
					blocked = 1'b1;
			PH_CHK_LEFT:
				if (own_addr[ev_k].rc.col == X_BEGIN)
					blocked = 1'b1;
			default:
			begin
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			rd_addr <= '0;
			moves   <= '0;
		end
		else if (is_chk)
		begin
			if (ctl.idx <= 3'd3)
				rd_addr <= rd_tgt;
			if (ctl.idx == 3'd0)
				moves <= moves_t'(moves | sel); // Assume free
			else if (ev_win && blocked)
				moves <= moves_t'(moves & ~sel);
		end
	end

	// Read port quiet outside the checks
	assert property (@(posedge clk) disable iff (!rst_n)
		!is_chk |=> $stable(rd_addr));

endmodule

// File: flist.f
tetris_pkg.sv
frame_sequencer.sv
shape_rom.sv
piece_state.sv
collision_checker.sv
board_writer.sv
tetris_game.sv
tb_board_ram.sv
tb_tetris_game.sv

// File: frame_sequencer.sv
module frame_sequencer import tetris_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       en,
	output frame_ctl_t ctl,
	output piece_id_t  random_id
);

	logic       en_q;
	logic       en_rise;
	logic [5:0] step;      // Holds at FRAME_STEPS when idle
	logic       busy;
	logic       frame_end;
	logic [2:0] grav_cnt;  // Frames mod GRAVITY_PERIOD
	logic [2:0] input_cnt; // Frames mod INPUT_PERIOD

	assign en_rise   = en & ~en_q;
	assign busy      = step < FRAME_STEPS;
	assign frame_end = step == FRAME_STEPS - 6'd1;

	////////////////////
	// Step counter
	////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			en_q <= 1'b0;
			step <= FRAME_STEPS;
		end
		else
		begin
			en_q <= en;
			if (busy)
				step <= step + 6'd1; // Edges mid-frame are dropped here
			else if (en_rise)
				step <= '0;
		end
	end

	// Frame rate counters, advance only between frames
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			grav_cnt  <= '0;
			input_cnt <= '0;
		end
		else if (frame_end)
		begin
			grav_cnt  <= (grav_cnt == GRAVITY_PERIOD - 3'd1) ? '0 : grav_cnt + 3'd1;
			input_cnt <= (input_cnt == INPUT_PERIOD - 3'd1) ? '0 : input_cnt + 3'd1;
		end
	end

	// Free running, sampled whenever a piece lands
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			random_id <= 3'd1;
		else
			random_id <= (random_id == NUM_PIECES) ? 3'd1 : random_id + 3'd1;
	end

	////////////////////
	// Phase decode
	////////////////////
	always_comb
	begin
		ctl.idx          = step[2:0]; // Phases start on multiples of 4
		ctl.gravity_tick = grav_cnt == GRAVITY_PERIOD - 3'd1;
		ctl.input_ok     = input_cnt == '0;
		ctl.phase        = PH_IDLE;
		if (step < STEP_CHK_LEFT)
			ctl.phase = PH_CHK_DOWN;
		else if (step < STEP_CHK_RIGHT)
			ctl.phase = PH_CHK_LEFT;
		else if (step < STEP_CHK_ROT)
			ctl.phase = PH_CHK_RIGHT;
		else if (step < STEP_ERASE)
			ctl.phase = PH_CHK_ROT;
		else if (step < STEP_UPDATE)
			ctl.phase = PH_ERASE;
		else if (step == STEP_UPDATE)
			ctl.phase = PH_UPDATE;
		else if (step >= STEP_WRITE && step < STEP_SPAWN)
			ctl.phase = PH_WRITE;
		else if (step == STEP_SPAWN)
			ctl.phase = PH_SPAWN;
	end

	// Spawned id must be a real piece
	assert property (@(posedge clk) disable iff (!rst_n)
		random_id inside {[3'd1 : NUM_PIECES]});

endmodule

// File: piece_state.sv
module piece_state import tetris_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  frame_ctl_t ctl,
	input  moves_t     moves,
	input  btn_t       btn,
	input  piece_id_t  random_id,
	output piece_t     piece,
	output shape_t     shape,
	output status_t    status
);

	shape_t rom_shape;  // Offsets for current id and rot
	logic   landed_now; // Gravity frame, floor or stack below
	logic   landed;     // Kept from update to spawn
	logic   reload;     // Shape load strobe
	logic   side_ok;    // Common gate for sideways and rotate
	logic   go_right;
	logic   go_left;
	logic   go_rot;

	shape_rom u_shape_rom (
		.id    (piece.id),
		.rot   (piece.rot),
		.shape (rom_shape)
	);

	assign landed_now = ctl.gravity_tick & ~moves.can_down;
	assign side_ok    = ctl.input_ok & ~landed_now;
	assign go_right   = side_ok & btn.right & ~btn.left & moves.can_right; // Both pressed cancel
	assign go_left    = side_ok & btn.left & ~btn.right & moves.can_left;
	assign go_rot     = side_ok & btn.rot & moves.can_rot;

	////////////////////
	// Update and spawn
	////////////////////
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			piece  <= '{id: 3'd1, rot: 2'd0, pos_x: SPAWN_X, pos_y: SPAWN_Y};
			landed <= 1'b0;
			reload <= 1'b1; // Pick up first shape right after reset
		end
		else
		begin
			reload <= 1'b0;
			case (ctl.phase)
				PH_UPDATE:
				begin
					if (ctl.gravity_tick && moves.can_down)
						piece.pos_y <= piece.pos_y + 5'd1;
					if (go_right)
						piece.pos_x <= piece.pos_x + 6'd1;
					else if (go_left)
						piece.pos_x <= piece.pos_x - 6'd1;
					if (go_rot)
						piece.rot <= piece.rot + 2'd1; // Wraps mod 4
					landed <= landed_now;
					reload <= 1'b1;
				end
				PH_SPAWN:
				begin
					if (landed)
					begin
						piece  <= '{id: random_id, rot: 2'd0, pos_x: SPAWN_X, pos_y: SPAWN_Y};
						reload <= 1'b1;
					end
				end
				default:
				begin
				end
			endcase
		end
	end

	// Offsets registered one cycle after a change
	always_ff @(posedge clk)
	begin
		if (reload)
			shape <= rom_shape;
	end

	assign status = '{id: piece.id, rot: piece.rot};

endmodule

// File: shape_rom.sv
module shape_rom import tetris_pkg::*; (
	input  piece_id_t id,
	input  rot_t      rot,
	output shape_t    shape
);

	// Each nibble is one cell as {row, col} in the 4x4 box
	always_comb
	begin
		case ({id, rot})
			// Bar
			{3'd1, 2'd0}: shape = shape_t'(16'h4567);
			{3'd1, 2'd1}: shape = shape_t'(16'h26AE);
			{3'd1, 2'd2}: shape = shape_t'(16'h89AB);
			{3'd1, 2'd3}: shape = shape_t'(16'h159D);
			// Square, same in all rotations
			{3'd2, 2'd0}: shape = shape_t'(16'h1256);
			{3'd2, 2'd1}: shape = shape_t'(16'h1256);
			{3'd2, 2'd2}: shape = shape_t'(16'h1256);
			{3'd2, 2'd3}: shape = shape_t'(16'h1256);
			// First L, hook top left
			{3'd3, 2'd0}: shape = shape_t'(16'h0456);
			{3'd3, 2'd1}: shape = shape_t'(16'h1259);
			{3'd3, 2'd2}: shape = shape_t'(16'h456A);
			{3'd3, 2'd3}: shape = shape_t'(16'h1589);
			// Second L, hook top right
			{3'd4, 2'd0}: shape = shape_t'(16'h2456);
			{3'd4, 2'd1}: shape = shape_t'(16'h159A);
			{3'd4, 2'd2}: shape = shape_t'(16'h4568);
			{3'd4, 2'd3}: shape = shape_t'(16'h0159);
			// First zigzag
			{3'd5, 2'd0}: shape = shape_t'(16'h1245);
			{3'd5, 2'd1}: shape = shape_t'(16'h156A);
			{3'd5, 2'd2}: shape = shape_t'(16'h5689);
			{3'd5, 2'd3}: shape = shape_t'(16'h0459);
			// Second zigzag
			{3'd6, 2'd0}: shape = shape_t'(16'h0156);
			{3'd6, 2'd1}: shape = shape_t'(16'h2569);
			{3'd6, 2'd2}: shape = shape_t'(16'h459A);
			{3'd6, 2'd3}: shape = shape_t'(16'h1458);
			// T
			{3'd7, 2'd0}: shape = shape_t'(16'h1456);
			{3'd7, 2'd1}: shape = shape_t'(16'h1569);
			{3'd7, 2'd2}: shape = shape_t'(16'h4569);
			{3'd7, 2'd3}: shape = shape_t'(16'h1459);
			default:      shape = '0; // Code 0 is empty, no shape
		endcase
	end

endmodule

// File: tb_board_ram.sv
module tb_board_ram import tetris_pkg::*; (
	input  logic        clk,
	input  board_addr_t rd_addr,
	output cell_t       rd_data,
	input  board_addr_t wr_addr,
	input  cell_t       wr_data,
	input  logic        wr_en
);

	cell_t mem [2048]; // One cell code per board position

	initial
	begin
		rd_data = '0;
		for (int i = 0; i < 2048; i++)
			mem[i] = '0; // Board starts empty
	end

	// Read data one clock behind the address
	always @(posedge clk)
	begin
		rd_data <= mem[rd_addr.flat];
		if (wr_en)
			mem[wr_addr.flat] <= wr_data; // Write port always accepts
	end

endmodule

// File: tb_tetris_game.sv
module tb_tetris_game import tetris_pkg::*; ();

	localparam int FRAMES    = 240;
	localparam int FRAME_CYC = 64; // Clocks between en pulses
	localparam int PERIOD    = 4;
	localparam int RUN_LIMIT = (FRAMES + 4) * FRAME_CYC * PERIOD + 400;

	logic        clk;
	logic        rst_n;
	logic        en;
	btn_t        btn;
	cell_t       rd_data;
	board_addr_t rd_addr;
	board_addr_t wr_addr;
	cell_t       wr_data;
	logic        wr_en;
	status_t     status;

	int          seed;
	int          frame;
	int          value_errs;
	int          other_errs;
	cell_t       shadow [2048];  // Board as seen through the write port
	logic [10:0] erase_q [$];    // Zero writes of this frame
	logic [10:0] write_q [$];    // Piece writes of this frame
	logic [10:0] stack_q [$];    // Cells of landed pieces
	logic [10:0] cur_set [4];    // Cells drawn before this frame
	logic [10:0] pred_set [4];
	logic        fresh;          // New piece, cells not yet seen
	logic        landing;        // Predicted for the frame under way
	logic        set_known;
	logic        rot_known;
	rot_t        pred_rot;
	rot_t        base_rot;
	piece_id_t   base_id;

	// Check strobes and snapshots, set on the falling edge
	logic        reset_stb;
	logic        eval_stb;
	logic        cnt_ok;
	logic        chk_erase;
	logic        chk_write;
	logic        chk_rot;
	logic        chk_id;
	logic        chk_land;
	logic        box_ok;
	logic        stack_ok;
	int          n_erase;
	int          n_write;
	logic [43:0] erase_key;
	logic [43:0] exp_erase_key;
	logic [43:0] write_key;
	logic [43:0] exp_write_key;
	rot_t        exp_rot;
	piece_id_t   exp_id;

	tetris_game UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.en      (en),
		.btn     (btn),
		.rd_data (rd_data),
		.rd_addr (rd_addr),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en),
		.status  (status)
	);

	tb_board_ram u_board_ram (
		.clk     (clk),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en)
	);

	always #(PERIOD / 2) clk = ~clk;

	// Order-free key of a four-cell set
	function automatic logic [43:0] set_key(input logic [10:0] s [4]);
		logic [10:0] v [4];
		logic [10:0] t;
		v = s;
		for (int i = 0; i < 3; i++)
			for (int j = 0; j < 3 - i; j++)
				if (v[j] > v[j + 1])
				begin
					t        = v[j];
					v[j]     = v[j + 1];
					v[j + 1] = t;
				end
		return {v[3], v[2], v[1], v[0]};
	endfunction

	// Taken by something other than the piece itself
	function automatic logic occupied(input logic [10:0] a);
		logic own;
		own = 1'b0;
		for (int k = 0; k < 4; k++)
			if (cur_set[k] == a)
				own = 1'b1;
		return shadow[a] != '0 && !own;
	endfunction

	function automatic logic in_spawn_box(input logic [10:0] s [4]);
		logic [4:0] r0;
		logic [5:0] c0;
		logic       ok;
		r0 = Y_BEGIN + SPAWN_Y;
		c0 = X_BEGIN + SPAWN_X;
		ok = 1'b1;
		for (int k = 0; k < 4; k++)
			if (s[k][10:6] < r0 || s[k][10:6] > r0 + 5'd3 ||
				s[k][5:0] < c0 || s[k][5:0] > c0 + 6'd3)
				ok = 1'b0;
		return ok;
	endfunction

	function automatic logic stack_kept();
		logic ok;
		ok = 1'b1;
		foreach (stack_q[i])
			if (shadow[stack_q[i]] == '0)
				ok = 1'b0; // Landed cell was wiped
		return ok;
	endfunction

	////////////////////
	// Move prediction
	////////////////////
	task automatic predict_move();
		logic       gravity;
		logic       in_ok;
		logic       can_down;
		logic       can_left;
		logic       can_right;
		logic       free;
		logic       go_left;
		logic       go_right;
		logic [4:0] r;
		logic [5:0] c;
		logic [4:0] dr;
		logic [5:0] dc;
		gravity   = (frame % int'(GRAVITY_PERIOD)) == int'(GRAVITY_PERIOD) - 1;
		in_ok     = (frame % int'(INPUT_PERIOD)) == 0;
		can_down  = 1'b1;
		can_left  = 1'b1;
		can_right = 1'b1;
		for (int k = 0; k < 4; k++)
		begin
			r = cur_set[k][10:6];
			c = cur_set[k][5:0];
			if (r + 5'd1 == Y_END || occupied({r + 5'd1, c}))
				can_down = 1'b0;
			if (c == X_BEGIN || occupied({r, c - 6'd1}))
				can_left = 1'b0; // Wall test on current column
			if (c + 6'd1 == X_END || occupied({r, c + 6'd1}))
				can_right = 1'b0;
		end
		// Any rotation stays within three cells of each cell
		free = 1'b1;
		for (int i = -3; i <= 3; i++)
			for (int j = -3; j <= 3; j++)
				if (occupied({5'(cur_set[0][10:6] + i), 6'(cur_set[0][5:0] + j)}))
					free = 1'b0;
		landing  = gravity && !can_down;
		go_right = in_ok && !landing && btn.right && !btn.left && can_right;
		go_left  = in_ok && !landing && btn.left && !btn.right && can_left;
		dr = (gravity && can_down) ? 5'd1 : 5'd0;
		dc = go_right ? 6'd1 : (go_left ? 6'h3f : 6'd0);
		for (int k = 0; k < 4; k++)
			pred_set[k] = {cur_set[k][10:6] + dr, cur_set[k][5:0] + dc};
		if (in_ok && !landing && btn.rot)
		begin
			set_known = 1'b0; // New cells depend on the shape
			rot_known = free;
			pred_rot  = base_rot + 2'd1;
		end
		else
		begin
			set_known = 1'b1;
			rot_known = 1'b1;
			pred_rot  = base_rot;
		end
	endtask

	// Buttons and expectations for the next frame
	task automatic start_frame();
		int r;
		r        = $random(seed);
		base_id  = status.id;
		base_rot = status.rot;
		btn      = '0;
		if (!fresh)
		begin
			if (frame < 16)
			begin
				btn.right = 1'b1; // Walk into the right wall
				btn.rot   = (frame == 6);
			end
			else if (frame < 32)
				btn.left = 1'b1;
			else
			begin
				btn.rot   = (r[1:0] == 2'd0);
				btn.left  = r[2];
				btn.right = r[3];
			end
		end
		if (fresh)
		begin
			landing   = 1'b0;
			set_known = 1'b0;
			rot_known = 1'b1;
			pred_rot  = 2'd0;
		end
		else
			predict_move();
		erase_q.delete();
		write_q.delete();
	endtask

	task automatic score_frame();
		logic [10:0] e [4];
		logic [10:0] w [4];
		n_erase = erase_q.size();
		n_write = write_q.size();
		cnt_ok  = n_erase == 4 && n_write == 4;
		for (int k = 0; k < 4; k++)
		begin
			e[k] = (k < n_erase) ? erase_q[k] : '0;
			w[k] = (k < n_write) ? write_q[k] : '0;
		end
		erase_key     = set_key(e);
		write_key     = set_key(w);
		exp_erase_key = fresh ? write_key : set_key(cur_set); // Fresh piece erases itself
		exp_write_key = set_key(pred_set);
		chk_erase     = cnt_ok;
		chk_write     = cnt_ok && set_known;
		chk_rot       = rot_known && !landing;
		exp_rot       = pred_rot;
		chk_id        = !landing;
		exp_id        = base_id;
		chk_land      = landing;
		box_ok        = !fresh || in_spawn_box(w);
		stack_ok      = stack_kept();
		eval_stb      = 1'b1;
		cur_set = w;
		if (landing)
			for (int k = 0; k < 4; k++)
				stack_q.push_back(w[k]);
		fresh = landing;
	endtask

	// Shadow of every board write
	always @(negedge clk)
	begin
		if (rst_n && wr_en)
		begin
			if (wr_data == '0)
				erase_q.push_back(wr_addr.flat);
			else
				write_q.push_back(wr_addr.flat);
			shadow[wr_addr.flat] = wr_data;
		end
	end

	////////////////////
	// Checks
	////////////////////
	assert property (@(posedge clk) reset_stb |->
		!wr_en && rd_addr.flat == '0 && status.id == 3'd1 && status.rot == 2'd0)
	else
	begin
		value_errs++;
		$display("error reset wr_en 0x%h rd_addr 0x%h status 0x%h, expected 0x0 0x000 0x04",
			$sampled(wr_en), $sampled(rd_addr), $sampled(status));
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		wr_en && wr_data != '0 |-> wr_data == status.id)
	else
	begin
		value_errs++;
		$display("error wr_data 0x%h, expected status.id 0x%h", $sampled(wr_data), $sampled(status.id));
	end

	assert property (@(posedge clk) eval_stb |-> cnt_ok)
	else
	begin
		other_errs++;
		$display("Frame had %0d erase and %0d piece writes instead of four each", n_erase, n_write);
	end

	assert property (@(posedge clk) eval_stb && chk_erase |-> erase_key == exp_erase_key)
	else
	begin
		value_errs++;
		$display("error wr_addr erase set 0x%h, expected 0x%h", erase_key, exp_erase_key);
	end

	assert property (@(posedge clk) eval_stb && chk_write |-> write_key == exp_write_key)
	else
	begin
		value_errs++;
		$display("error wr_addr write set 0x%h, expected 0x%h", write_key, exp_write_key);
	end

	assert property (@(posedge clk) eval_stb && chk_rot |-> status.rot == exp_rot)
	else
	begin
		value_errs++;
		$display("error status.rot 0x%h, expected 0x%h", $sampled(status.rot), exp_rot);
	end

	assert property (@(posedge clk) eval_stb && chk_id |-> status.id == exp_id)
	else
	begin
		value_errs++;
		$display("error status.id 0x%h, expected 0x%h", $sampled(status.id), exp_id);
	end

	// New piece after landing
	assert property (@(posedge clk) eval_stb && chk_land |-> status.id != '0 && status.rot == '0)
	else
	begin
		value_errs++;
		$display("error status 0x%h after landing, expected nonzero id and rot 0x0",
			$sampled(status));
	end

	assert property (@(posedge clk) eval_stb |-> box_ok && stack_ok)
	else
	begin
		other_errs++;
		$display("New piece outside the spawn box or a landed cell was cleared");
	end

	////////////////////
	// Stimulus
	////////////////////
	initial
	begin
		seed       = 32'h9916_734e;
		clk        = 1'b0;
		rst_n      = 1'b0;
		en         = 1'b0;
		btn        = '0;
		value_errs = 0;
		other_errs = 0;
		reset_stb  = 1'b0;
		eval_stb   = 1'b0;
		fresh      = 1'b1; // First piece appears at frame 0
		for (int i = 0; i < 2048; i++)
			shadow[i] = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n     = 1'b1;
		reset_stb = 1'b1;
		@(negedge clk);
		reset_stb = 1'b0;
		for (frame = 0; frame < FRAMES; frame++)
		begin
			if (frame > 0)
				score_frame();
			start_frame();
			en = 1'b1;
			@(negedge clk);
			en       = 1'b0;
			eval_stb = 1'b0;
			repeat (FRAME_CYC - 1) @(negedge clk);
		end
		score_frame();
		@(negedge clk);
		eval_stb = 1'b0;
		@(negedge clk);
		$display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog sized from the frame count
	initial
	begin
		#(RUN_LIMIT);
		$display("Run did not finish within %0d time units", RUN_LIMIT);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: tetris_game.sv
module tetris_game import tetris_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        en,
	input  btn_t        btn,
	input  cell_t       rd_data,
	output board_addr_t rd_addr,
	output board_addr_t wr_addr,
	output cell_t       wr_data,
	output logic        wr_en,
	output status_t     status
);

	frame_ctl_t ctl;       // Frame schedule to all blocks
	piece_id_t  random_id;
	piece_t     piece;
	shape_t     shape;     // Current cell offsets
	moves_t     moves;

	frame_sequencer u_frame_sequencer (
		.clk       (clk),
		.rst_n     (rst_n),
		.en        (en),
		.ctl       (ctl),
		.random_id (random_id)
	);

	piece_state u_piece_state (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctl       (ctl),
		.moves     (moves),
		.btn       (btn),
		.random_id (random_id),
		.piece     (piece),
		.shape     (shape),
		.status    (status)
	);

	// Board read side
	collision_checker u_collision_checker (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctl     (ctl),
		.piece   (piece),
		.shape   (shape),
		.rd_data (rd_data),
		.rd_addr (rd_addr),
		.moves   (moves)
	);

	// Board write side
	board_writer u_board_writer (
		.clk     (clk),
		.rst_n   (rst_n),
		.ctl     (ctl),
		.piece   (piece),
		.shape   (shape),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en)
	);

endmodule

// File: tetris_pkg.sv
package tetris_pkg;

	////////////////////
	// Board geometry
	////////////////////
	localparam logic [5:0] X_BEGIN = 6'd10; // First field column
	localparam logic [5:0] X_END   = 6'd20; // First column right of field
	localparam logic [4:0] Y_BEGIN = 5'd5;  // Top field row
	localparam logic [4:0] Y_END   = 5'd24; // Floor row, never occupied

	// Spawn point, relative to field corner
	localparam logic [5:0] SPAWN_X = 6'd5;
	localparam logic [4:0] SPAWN_Y = 5'd1;

	localparam logic [2:0] GRAVITY_PERIOD = 3'd4; // Frames per fall step
	localparam logic [2:0] INPUT_PERIOD   = 3'd2; // Frames per button action
	localparam logic [2:0] NUM_PIECES     = 3'd7;

	////////////////////
	// Frame schedule
	////////////////////
	localparam logic [5:0] STEP_CHK_DOWN  = 6'd0;
	localparam logic [5:0] STEP_CHK_LEFT  = 6'd8;
	localparam logic [5:0] STEP_CHK_RIGHT = 6'd16;
	localparam logic [5:0] STEP_CHK_ROT   = 6'd24;
	localparam logic [5:0] STEP_ERASE     = 6'd32; // Four cells
	localparam logic [5:0] STEP_UPDATE    = 6'd36; // Single step
	localparam logic [5:0] STEP_WRITE     = 6'd40; // Four cells
	localparam logic [5:0] STEP_SPAWN     = 6'd44;
	localparam logic [5:0] FRAME_STEPS    = 6'd48; // Idle from here on

	typedef logic [2:0] cell_t;     // 0 = empty
	typedef logic [2:0] piece_id_t; // Shape number and colour
	typedef logic [1:0] rot_t;

	// One cell inside the 4x4 piece box
	typedef struct packed {
		logic [1:0] row;
		logic [1:0] col;
	} cell_ofs_t;

	typedef cell_ofs_t [3:0] shape_t;

	typedef struct packed {
		logic [4:0] row;
		logic [5:0] col;
	} board_rc_t;

	// Memory sees a flat word, game logic sees row and column
	typedef union packed {
		logic [10:0] flat;
		board_rc_t   rc;
	} board_addr_t;

	typedef struct packed {
		piece_id_t  id;
		rot_t       rot;
		logic [5:0] pos_x; // Box corner, field relative
		logic [4:0] pos_y;
	} piece_t;

	typedef struct packed {
		logic rot;
		logic left;
		logic right;
	} btn_t;

	typedef enum logic [3:0] {
		PH_IDLE,
		PH_CHK_DOWN,
		PH_CHK_LEFT,
		PH_CHK_RIGHT,
		PH_CHK_ROT,
		PH_ERASE,
		PH_UPDATE,
		PH_WRITE,
		PH_SPAWN
	} phase_t;

	typedef struct packed {
		phase_t     phase;
		logic [2:0] idx;          // Step inside phase
		logic       gravity_tick; // Steady for whole frame
		logic       input_ok;
	} frame_ctl_t;

	typedef struct packed {
		logic can_down;
		logic can_left;
		logic can_right;
		logic can_rot;
	} moves_t;

	typedef struct packed {
		piece_id_t id;
		rot_t      rot;
	} status_t;

	// Absolute board position of one piece cell
	function automatic board_addr_t cell_addr(input piece_t p, input cell_ofs_t ofs);
		board_addr_t a;
		a.rc.row = Y_BEGIN + p.pos_y + 5'(ofs.row);
		a.rc.col = X_BEGIN + p.pos_x + 6'(ofs.col);
		return a;
	endfunction

endpackage
